// ==== Bender.yml ====
package:
  name: fetch_subsystem

sources:
  - target: rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/pc_gen.sv
      - rtl/fetch_fifo.sv
      - rtl/instr_decoder.sv
      - rtl/fetch_top.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_fetch_top.sv

// ==== flist.f ====
+incdir+tb
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/fetch_fifo.sv
rtl/instr_decoder.sv
rtl/fetch_top.sv
tb/tb_fetch_top.sv

// ==== rtl/fetch_fifo.sv ====
// Circular FIFO of fetched PC and instruction pairs between the PC generator and the decoder
`timescale 1ns/1ps

module fetch_fifo #(
  parameter int unsigned DEPTH = 4  // Power of two no smaller than 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,       // Drop everything at the next edge
  // Push side
  input  logic                       push_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] push_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] push_instr_i,
  output logic                       push_ready_o,
  // Pop side
  output logic                       pop_valid_o,
  output logic [fetch_pkg::XLEN-1:0] pop_pc_o,
  output logic [fetch_pkg::XLEN-1:0] pop_instr_o,
  input  logic                       pop_ready_i
);
  import fetch_pkg::*;

  localparam int unsigned    PTR_W    = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  logic [XLEN-1:0]  pc_mem    [DEPTH];
  logic [XLEN-1:0]  instr_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;   // Wrap naturally
  logic [PTR_W:0]   count_q;               // One extra bit to tell full from empty
  logic             push_fire, pop_fire;

  assign push_ready_o = (count_q != FULL_CNT);
  assign pop_valid_o  = (count_q != '0);
  assign pop_pc_o     = pc_mem[rd_ptr_q];     // Head word is visible the cycle after the push
  assign pop_instr_o  = instr_mem[rd_ptr_q];

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin          // Flush wins over a push
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_fire)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_fire) begin
      pc_mem[wr_ptr_q]    <= push_pc_i;
      instr_mem[wr_ptr_q] <= push_instr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Producer holds its word back while the FIFO is full
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    count_q == FULL_CNT |-> !push_valid_i);

  // A pop never reads a slot that has not been written
  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
    pop_fire |-> (rd_ptr_q != wr_ptr_q) || (count_q == FULL_CNT));

endmodule

// ==== rtl/fetch_pkg.sv ====
// Shared widths, opcodes and instruction formats of the fetch subsystem, imported by its modules
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN        = 32;  // Data and address width
  localparam int unsigned INSTR_BYTES = 4;   // One instruction word per fetch

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Six bit major opcode in the top of every word
  // Any encoding not listed here decodes as illegal
  typedef enum logic [5:0] {
    OPC_NOP    = 6'h00,  // No operation
    OPC_ALU    = 6'h01,  // Register to register arithmetic
    OPC_LOAD   = 6'h02,  // Memory read
    OPC_STORE  = 6'h03,  // Memory write
    OPC_BRANCH = 6'h04,  // Conditional branch, resolved in fetch
    OPC_JUMP   = 6'h05   // Unconditional jump
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Exception vectors
  ////////////////////////////////////////////////////////////

  // Low byte of the vector, the upper bits come from the boot address
  localparam logic [7:0] EXC_ILLINSN_OFS = 8'h00;  // Illegal instruction
  localparam logic [7:0] EXC_RESET_OFS   = 8'h80;  // Reset entry

  ////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////

  // Branch and jump layout
  typedef struct packed {
    opcode_e            opcode;  // [31:26]
    logic               cond;    // [25] 1 means taken
    logic signed [24:0] disp;    // [24:0] word displacement
  } branch_fmt_t;

  // Register layout for ALU and memory ops
  typedef struct packed {
    opcode_e     opcode;  // [31:26]
    logic [4:0]  rd;      // Destination register
    logic [4:0]  ra;      // First source
    logic [4:0]  rb;      // Second source
    logic [10:0] func;    // Minor function code
  } reg_fmt_t;

  // Same 32 bit word seen through either layout
  // The opcode sits at the same place in both
  typedef union packed {
    branch_fmt_t branch;
    reg_fmt_t    regf;
  } instr_u;

  // Canonical NOP, also stands in for words that came back with a bus error
  localparam logic [XLEN-1:0] NOP_WORD = {OPC_NOP, 26'd0};

endpackage

// ==== rtl/fetch_top.sv ====
// Top level of the fetch subsystem joining the PC generator, the fetch FIFO and the decoder
`timescale 1ns/1ps

module fetch_top #(
  parameter int unsigned FIFO_DEPTH = 4   // Power of two, at least 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
  // AXI4-Lite read master towards instruction memory
  output logic [fetch_pkg::XLEN-1:0] araddr_o,
  output logic [2:0]                 arprot_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic [1:0]                 rresp_i,
  input  logic                       rvalid_i,
  output logic                       rready_o,
  // ID stage
  output logic                       id_valid_o,
  output logic [fetch_pkg::XLEN-1:0] id_pc_o,
  output fetch_pkg::instr_u          id_instr_o,
  output logic                       id_illegal_o,
  input  logic                       id_ready_i
);
  import fetch_pkg::*;

  logic            push_valid, push_ready;   // PC generator to FIFO
  logic [XLEN-1:0] push_pc, push_instr;
  logic            pop_valid, pop_ready;     // FIFO to decoder
  logic [XLEN-1:0] pop_pc, pop_instr;
  logic            redirect_valid;           // Also flushes the FIFO
  logic [XLEN-1:0] redirect_pc;

  pc_gen u_pc_gen (
    .clk, .rst_n, .boot_addr_i,
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .araddr_o, .arprot_o, .arvalid_o, .arready_i,
    .rdata_i, .rresp_i, .rvalid_i, .rready_o,
    .push_valid_o     (push_valid),
    .push_pc_o        (push_pc),
    .push_instr_o     (push_instr),
    .push_ready_i     (push_ready)
  );

  fetch_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk, .rst_n,
    .flush_i      (redirect_valid),   // Wrong path words are dropped
    .push_valid_i (push_valid),
    .push_pc_i    (push_pc),
    .push_instr_i (push_instr),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_pc_o     (pop_pc),
    .pop_instr_o  (pop_instr),
    .pop_ready_i  (pop_ready)
  );

  instr_decoder u_instr_decoder (
    .clk, .rst_n, .boot_addr_i,
    .pop_valid_i      (pop_valid),
    .pop_pc_i         (pop_pc),
    .pop_instr_i      (pop_instr),
    .pop_ready_o      (pop_ready),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .id_valid_o, .id_pc_o, .id_instr_o, .id_illegal_o, .id_ready_i
  );

endmodule

// ==== rtl/instr_decoder.sv ====
// Pops fetched words, resolves branches and illegal opcodes as redirects and feeds the ID stage
`timescale 1ns/1ps

module instr_decoder (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,     // Base of the exception vectors
  // From the fetch FIFO head
  input  logic                       pop_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] pop_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] pop_instr_i,
  output logic                       pop_ready_o,
  // Redirect back to the PC generator
  output logic                       redirect_valid_o,
  output logic [fetch_pkg::XLEN-1:0] redirect_pc_o,
  // ID stage
  output logic                       id_valid_o,
  output logic [fetch_pkg::XLEN-1:0] id_pc_o,
  output fetch_pkg::instr_u          id_instr_o,
  output logic                       id_illegal_o,
  input  logic                       id_ready_i
);
  import fetch_pkg::*;

  instr_u          head;        // FIFO head seen in both formats
  logic            pop_fire;
  logic            legal;       // Opcode is one of the known ones
  logic            take;        // Jump or taken branch
  logic [XLEN-1:0] disp_ext;    // Sign extended word displacement
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] exc_target;

  assign head = pop_instr_i;

  // Pop whenever the output register is free or draining
  assign pop_ready_o = ~id_valid_o | id_ready_i;
  assign pop_fire    = pop_valid_i & pop_ready_o;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    legal = 1'b1;
    take  = 1'b0;
    case (head.regf.opcode)
      OPC_NOP, OPC_ALU, OPC_LOAD, OPC_STORE: take = 1'b0;   // Fall through
      OPC_BRANCH: take = head.branch.cond;
      OPC_JUMP:   take = 1'b1;
      default:    legal = 1'b0;                            // Unknown encoding
    endcase
  end

  assign disp_ext   = XLEN'(head.branch.disp);                        // Signed field
  assign br_target  = pop_pc_i + {disp_ext[XLEN-3:0], 2'b00};        // Words to bytes
  assign exc_target = {boot_addr_i[XLEN-1:8], EXC_ILLINSN_OFS};

  // One cycle pulse together with the pop that caused it
  assign redirect_valid_o = pop_fire & (take | ~legal);
  assign redirect_pc_o    = legal ? br_target : exc_target;

  ////////////////////////////////////////////////////////////
  // ID output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (pop_ready_o) begin
      id_valid_o <= pop_valid_i;     // Empties when nothing is popped
    end
  end

  // Branches and illegal words still go to ID
  always_ff @(posedge clk) begin
    if (pop_fire) begin
      id_pc_o      <= pop_pc_i;
      id_instr_o   <= head;
      id_illegal_o <= ~legal;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // The flush leaves the FIFO empty so a second redirect cannot follow
  a_redirect_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid_o |=> !redirect_valid_o);

  a_id_stable : assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o && !id_ready_i |=> id_valid_o && $stable(id_instr_o) && $stable(id_pc_o));

endmodule

// ==== rtl/pc_gen.sv ====
// Fetch PC register and AXI4-Lite read master that pushes each fetched word into the fetch FIFO
`timescale 1ns/1ps

module pc_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,       // First fetch address after reset
  // Redirect from the decoder
  input  logic                       redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  // AXI4-Lite AR channel
  output logic [fetch_pkg::XLEN-1:0] araddr_o,
  output logic [2:0]                 arprot_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,
  // AXI4-Lite R channel
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic [1:0]                 rresp_i,
  input  logic                       rvalid_i,
  output logic                       rready_o,
  // Push side of the fetch FIFO
  output logic                       push_valid_o,
  output logic [fetch_pkg::XLEN-1:0] push_pc_o,
  output logic [fetch_pkg::XLEN-1:0] push_instr_o,
  input  logic                       push_ready_i
);
  import fetch_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;  // Waiting for the boot load
  localparam logic [1:0] S_ADDR = 2'd1;  // AR presented
  localparam logic [1:0] S_DATA = 2'd2;  // Waiting for the R beat

  localparam logic [2:0] AXI_PROT_INSTR = 3'b100;  // Instruction, secure, unprivileged
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  logic [1:0]      state_q, state_d;
  logic [XLEN-1:0] pc_q, pc_d;     // Next word to fetch
  logic [XLEN-1:0] araddr_q;       // Address of the read in flight
  logic            boot_q;         // Set for one cycle after reset
  logic            stale_q, stale_d;
  logic            ar_fire;
  logic            r_fire;
  logic            good_beat;      // Beat that belongs to the current path

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  assign ar_fire   = arvalid_o & arready_i;
  assign r_fire    = rvalid_i & rready_o;
  assign good_beat = r_fire & ~stale_q;

  assign arvalid_o = (state_q == S_ADDR);
  assign araddr_o  = araddr_q;         // Held steady while AR waits
  assign arprot_o  = AXI_PROT_INSTR;
  assign rready_o  = (state_q == S_DATA) & push_ready_i;  // Beat waits when the FIFO is full

  // Push in the same cycle the beat is taken
  assign push_valid_o = good_beat;
  assign push_pc_o    = araddr_q;
  assign push_instr_o = (rresp_i == AXI_RESP_OKAY) ? rdata_i : NOP_WORD;  // Bus error becomes NOP

  ////////////////////////////////////////////////////////////
  // Next PC and read FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    pc_d = pc_q;                                  // Hold by default
    if (boot_q) begin
      pc_d = boot_addr_i;
    end else if (redirect_valid_i) begin
      pc_d = redirect_pc_i;                       // Branch target or exception vector
    end else if (good_beat) begin
      pc_d = pc_q + XLEN'(INSTR_BYTES);           // Sequential
    end
  end

  always_comb begin
    state_d = state_q;
    stale_d = stale_q;
    case (state_q)
      S_IDLE: if (!boot_q) state_d = S_ADDR;
      S_ADDR: if (ar_fire) state_d = S_DATA;
      S_DATA: begin
        if (r_fire) begin
          state_d = S_ADDR;                       // Next AR one cycle after the beat
          stale_d = 1'b0;
        end
      end
      default: state_d = S_IDLE;
    endcase
    // A read already issued belongs to the old path
    if (redirect_valid_i && ((state_q == S_ADDR) || (state_q == S_DATA && !r_fire))) begin
      stale_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      pc_q    <= '0;
      boot_q  <= 1'b1;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      boot_q  <= 1'b0;
      stale_q <= stale_d;
    end
  end

  // Capture the address when a new AR starts
  always_ff @(posedge clk) begin
    if (state_d == S_ADDR && state_q != S_ADDR) araddr_q <= pc_d;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_ar_stable : assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

  a_ar_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_o |-> araddr_o[1:0] == 2'b00);

endmodule

// ==== tb/tb_fetch_checks.svh ====
// Compare tasks, LFSR, memory image lookup and reference model, included by the fetch testbench top
`ifndef TB_FETCH_CHECKS_SVH
`define TB_FETCH_CHECKS_SVH

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_pc(input string what, input logic [XLEN-1:0] exp_v,
                        input logic [XLEN-1:0] act_v);
  if (act_v !== exp_v) begin
    mismatches++;
    $display("MISMATCH %s %s: expected %h, actual %h", row_name[row], what, exp_v, act_v);
  end
endtask

task automatic check_instr(input string what, input instr_u exp_v, input instr_u act_v);
  if (act_v !== exp_v) begin
    mismatches++;
    $display("MISMATCH %s %s: expected %h, actual %h", row_name[row], what, exp_v, act_v);
  end
endtask

task automatic check_flag(input string what, input bit exp_v, input logic act_v);
  if (act_v !== exp_v) begin
    mismatches++;
    $display("MISMATCH %s %s: expected %b, actual %b", row_name[row], what, exp_v, act_v);
  end
endtask

////////////////////////////////////////////////////////////
// Random bits and memory image
////////////////////////////////////////////////////////////

// x^8 + x^6 + x^5 + x^4 + 1, new bit enters at the bottom
function automatic logic [7:0] lfsr_step(input logic [7:0] s);
  return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
endfunction

task automatic take_bits(input int n, output int v);
  int i;
  v = 0;
  for (i = 0; i < n; i++) begin
    lfsr_q = lfsr_step(lfsr_q);     // One step per bit
    v      = (v << 1) | lfsr_q[0];
  end
endtask

// Table entries first, elsewhere an ALU word made from the address
function automatic logic [XLEN-1:0] image_word(input int r, input logic [XLEN-1:0] a,
                                               output logic err);
  int k;
  err = 1'b0;
  for (k = 0; k < N_MEM; k++) begin
    if (mem_row[k] == r && mem_addr[k] == a) begin
      err = mem_err[k];
      return mem_data[k];
    end
  end
  return {OPC_ALU, a[27:2] ^ {20'd0, a[31:28], a[1:0]}};
endfunction

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Walks the image from the boot address and queues what ID should see
task automatic build_expected(input int r);
  logic [XLEN-1:0] pc;
  instr_u          w;
  logic            err;
  bit              ill;
  int              d;
  int              i;
  exp_pc.delete();
  exp_word.delete();
  exp_ill.delete();
  pc = {row_base[r], EXC_RESET_OFS};
  for (i = 0; i < row_items[r]; i++) begin
    w = image_word(r, pc, err);
    if (err) w = NOP_WORD;             // Bus error arrives as NOP
    case (w.branch.opcode)
      OPC_NOP, OPC_ALU, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JUMP: ill = 1'b0;
      default: ill = 1'b1;
    endcase
    exp_pc.push_back(pc);
    exp_word.push_back(w);
    exp_ill.push_back(ill);
    d = w.branch.disp;                 // Signed word count
    if (ill) begin
      pc = {row_base[r], EXC_ILLINSN_OFS};
    end else if (w.branch.opcode == OPC_JUMP || (w.branch.opcode == OPC_BRANCH && w.branch.cond)) begin
      pc = pc + d * 4;
    end else begin
      pc = pc + INSTR_BYTES;
    end
  end
endtask

`endif

// ==== tb/tb_fetch_top.sv ====
// Testbench of the fetch subsystem, runs a table of fetch scenarios against an AXI4-Lite memory model
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int N_ROWS = 6;
  localparam int N_MEM  = 9;
  localparam int CLK_NS = 20;

  logic            clk, rst_n;
  logic [XLEN-1:0] boot_addr_i, araddr_o, rdata_i, id_pc_o;
  logic [2:0]      arprot_o;
  logic [1:0]      rresp_i;
  logic            arvalid_o, arready_i, rvalid_i, rready_o;
  logic            id_valid_o, id_illegal_o, id_ready_i;
  instr_u          id_instr_o;

  // Stimulus table
  string       row_name  [N_ROWS];
  logic [23:0] row_base  [N_ROWS];  // Boot address is this joined with the reset offset
  logic [31:0] row_stall [N_ROWS];  // Set bit holds id_ready_i low in that cycle
  bit          row_rand  [N_ROWS];  // LFSR delays on AR and R
  int          row_items [N_ROWS];
  int              mem_row  [N_MEM];   // Sparse image, owning row per entry
  logic [XLEN-1:0] mem_addr [N_MEM];
  logic [XLEN-1:0] mem_data [N_MEM];
  bit              mem_err  [N_MEM];   // Answered with SLVERR

  logic [XLEN-1:0] exp_pc [$];
  instr_u          exp_word [$];
  bit              exp_ill [$];
  int              row, cyc, checked, mismatches, other_errs;
  logic [7:0]      lfsr_q;
  bit              table_ready;
  // Memory model state
  int              s_phase, s_cnt;      // 0 wait AR, 1 delay, 2 R presented
  logic [XLEN-1:0] s_addr;
  bit              ar_hit, r_hit;       // Handshake due at the coming rising edge

  `include "tb_fetch_checks.svh"

  fetch_top #(.FIFO_DEPTH(4)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [XLEN-1:0] br_word(input opcode_e op, input bit c, input int d);
    return {op, c, 25'(d)};
  endfunction

  task automatic add_row(input int i, input string n, input logic [23:0] base,
                         input logic [31:0] stall, input bit rnd, input int items);
    row_name[i]  = n;
    row_base[i]  = base;
    row_stall[i] = stall;
    row_rand[i]  = rnd;
    row_items[i] = items;
  endtask

  task automatic add_mem(input int k, input int r, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] w, input bit e);
    mem_row[k]  = r;
    mem_addr[k] = a;
    mem_data[k] = w;
    mem_err[k]  = e;
  endtask

  task automatic fill_table();
    add_row(0, "seq_fetch",      24'h000010, 32'h0000_0000, 1'b0, 8);
    add_row(1, "branch_jump",    24'h000020, 32'h0000_0000, 1'b0, 8);
    add_row(2, "illegal_opcode", 24'h000030, 32'h0000_0000, 1'b0, 6);
    add_row(3, "back_pressure",  24'h000040, 32'hFFFF_00F0, 1'b0, 12);
    add_row(4, "bus_error",      24'h000050, 32'h0000_0000, 1'b0, 6);
    add_row(5, "random_latency", 24'h000060, 32'h0000_0C30, 1'b1, 14);
    add_mem(0, 1, 32'h2084, br_word(OPC_BRANCH, 1'b0, 5), 1'b0);    // Not taken
    add_mem(1, 1, 32'h2088, br_word(OPC_BRANCH, 1'b1, 4), 1'b0);
    add_mem(2, 1, 32'h2098, br_word(OPC_JUMP, 1'b0, -16), 1'b0);    // Backwards
    add_mem(3, 2, 32'h3088, {6'h3A, 26'h0ABCDEF}, 1'b0);
    add_mem(4, 3, 32'h408C, br_word(OPC_JUMP, 1'b0, 3), 1'b0);
    add_mem(5, 4, 32'h5088, br_word(OPC_JUMP, 1'b0, 40), 1'b1);     // Must not jump
    add_mem(6, 5, 32'h6090, br_word(OPC_BRANCH, 1'b1, 2), 1'b0);
    add_mem(7, 5, 32'h60A4, {6'h2F, 26'h0}, 1'b0);
    add_mem(8, 5, 32'h6008, 32'hDEAD_BEEF, 1'b1);
  endtask

  task automatic draw_delay(output int d);
    if (row_rand[row]) take_bits(2, d);   // 0 to 3 cycles
    else d = 0;
  endtask

  // All inputs idle, reset held, model cleared
  task automatic drive_idle(input int r);
    rst_n       = 1'b0;
    boot_addr_i = {row_base[r], EXC_RESET_OFS};
    arready_i   = 1'b0;
    rvalid_i    = 1'b0;
    rdata_i     = '0;
    rresp_i     = 2'b00;
    id_ready_i  = 1'b0;
    s_phase     = 0;
    s_cnt       = 0;
    ar_hit      = 1'b0;
    r_hit       = 1'b0;
    cyc         = 0;
  endtask

  task automatic apply_reset(input int r);
    drive_idle(r);
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite read slave, one step per falling edge
  ////////////////////////////////////////////////////////////

  task automatic mem_step();
    logic err;
    if (ar_hit) begin
      arready_i = 1'b0;
      s_phase   = 1;
      draw_delay(s_cnt);
    end
    if (r_hit) begin
      rvalid_i = 1'b0;
      s_phase  = 0;
      draw_delay(s_cnt);
    end
    ar_hit = 1'b0;
    case (s_phase)
      0: if (arvalid_o) begin
        if (s_cnt == 0) begin
          arready_i = 1'b1;
          ar_hit    = 1'b1;
          s_addr    = araddr_o;
          check_flag("arprot_o[2]", 1'b1, arprot_o[2]);  // Instruction access
          if (araddr_o[1:0] != 2'b00) begin
            other_errs++;
            $display("Read address %h is not word aligned in %s", araddr_o, row_name[row]);
          end
        end else s_cnt--;
      end
      1: if (s_cnt == 0) begin
        rdata_i  = image_word(row, s_addr, err);
        rresp_i  = err ? 2'b10 : 2'b00;  // SLVERR or OKAY
        rvalid_i = 1'b1;
        s_phase  = 2;
      end else s_cnt--;
      default: ;
    endcase
    r_hit = rvalid_i & rready_o;
  endtask

  ////////////////////////////////////////////////////////////
  // Table loop
  ////////////////////////////////////////////////////////////

  initial begin : main
    int r;
    lfsr_q     = 8'd21;
    checked    = 0;
    mismatches = 0;
    other_errs = 0;
    row        = 0;
    fill_table();
    drive_idle(0);
    table_ready = 1'b1;
    for (r = 0; r < N_ROWS; r++) begin
      row = r;
      build_expected(r);
      @(negedge clk);
      apply_reset(r);
      while (exp_pc.size() > 0) begin
        @(negedge clk);
        mem_step();
        id_ready_i = ~row_stall[r][cyc % 32];
        cyc++;
        if (id_valid_o && id_ready_i) begin     // Taken at the next rising edge
          check_pc("id_pc_o", exp_pc.pop_front(), id_pc_o);
          check_instr("id_instr_o", exp_word.pop_front(), id_instr_o);
          check_flag("id_illegal_o", exp_ill.pop_front(), id_illegal_o);
          checked++;
        end
      end
    end
    $display("%0d items checked, %0d mismatches, %0d other errors",
             checked, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // 40 cycles per expected item plus slack
  initial begin : watchdog
    int limit;
    int k;
    wait (table_ready);
    limit = 100;
    for (k = 0; k < N_ROWS; k++) limit += 40 * row_items[k];
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, the ID stage stopped receiving items in %s",
             limit, row_name[row]);
    $display("Checks failed");
    $finish;
  end

endmodule
